/* cachePkg.sv */
package cachePkg;

	//////////////////////////////////////////////////////////////////////
	// Geometry
	//////////////////////////////////////////////////////////////////////

	localparam int AddrWidth    = 32; // CPU and memory byte address
	localparam int DataWidth    = 32; // One data word
	localparam int NumWays      = 4;  // Victim and touch rules assume four ways
	localparam int WordsPerLine = 4;  // 16 byte line
	localparam int OffsetWidth  = 4;  // Byte offset inside a line

	//////////////////////////////////////////////////////////////////////
	// Field types
	//////////////////////////////////////////////////////////////////////

	typedef logic [AddrWidth-1:0] addrT;
	typedef logic [DataWidth-1:0] wordT;
	typedef logic [1:0]           wayT;     // Way number
	typedef logic [1:0]           wordSelT; // Word inside a line

	// Controller states
	typedef enum logic [3:0]
	{
		idle,
		lookup,       // Tag compare on the latched address
		fillRequest,  // Raise memReq for one fill beat
		fillWait,     // Wait for memAck and capture the word
		fillRelease,  // Wait for memAck low
		writeRequest, // Raise memReq with memWe
		writeWait,
		writeRelease,
		respond       // cpuAck high until the request drops
	} ctrlStateT;

	// Maintenance opcodes, any other value is acknowledged and ignored
	typedef enum logic [3:0]
	{
		opInvalidateLine = 4'd3,
		opInvalidateAll  = 4'd4
	} opCodeT;

endpackage

/* tagLookupIf.sv */
interface tagLookupIf;

	// Controller to tag store
	cachePkg::addrT addr;           // Latched request address
	logic           touch;          // Set recently used bit of touchWay
	cachePkg::wayT  touchWay;
	logic           allocate;       // Write tag and valid into the victim way
	logic           invalidateLine; // Drop the hitting way
	logic           invalidateAll;  // Clear every valid and used bit

	// Tag store to controller
	logic           hit;
	cachePkg::wayT  hitWay;
	cachePkg::wayT  victimWay;

	modport ctrlPort
	(
		output addr, touch, touchWay, allocate, invalidateLine, invalidateAll,
		input  hit, hitWay, victimWay
	);

	modport storePort
	(
		input  addr, touch, touchWay, allocate, invalidateLine, invalidateAll,
		output hit, hitWay, victimWay
	);

endinterface

/* fillBeatCounter.sv */
module fillBeatCounter
(
	input  logic              clk,
	input  logic              rstN,
	input  logic              beatDone,  // One memory beat completed
	input  logic              beatClear, // Start of a new fill
	output cachePkg::wordSelT beatIndex,
	output logic              lastBeat
);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			beatIndex <= '0;
		else if (beatClear)
			beatIndex <= '0;
		else if (beatDone)
			beatIndex <= beatIndex + 1'b1; // Wraps after the fourth word
	end

	// High while the fourth word is on the bus
	assign lastBeat = (beatIndex == cachePkg::wordSelT'(cachePkg::WordsPerLine - 1));

endmodule

/* tagStore.sv */
module tagStore
#(
	parameter int NumSets = 16
)
(
	input logic           clk,
	input logic           rstN,
	tagLookupIf.storePort lookup
);

	localparam int IndexWidth = $clog2(NumSets);
	localparam int TagWidth   = cachePkg::AddrWidth - cachePkg::OffsetWidth - IndexWidth;

	logic [cachePkg::NumWays-1:0] validBits [NumSets];
	logic [cachePkg::NumWays-1:0] usedBits  [NumSets]; // Recently used bits
	logic [TagWidth-1:0]          tagArray  [NumSets][cachePkg::NumWays];

	logic [IndexWidth-1:0]        setIndex;
	logic [TagWidth-1:0]          addrTag;
	logic [cachePkg::NumWays-1:0] setValid;
	logic [cachePkg::NumWays-1:0] setUsed;
	logic [cachePkg::NumWays-1:0] hitVec;
	logic [cachePkg::NumWays-1:0] touchMask;
	logic [cachePkg::NumWays-1:0] touchedUsed;

	assign setIndex = lookup.addr[cachePkg::OffsetWidth +: IndexWidth];
	assign addrTag  = lookup.addr[cachePkg::AddrWidth-1 -: TagWidth];
	assign setValid = validBits[setIndex];
	assign setUsed  = usedBits[setIndex];

	//////////////////////////////////////////////////////////////////////
	// Hit and victim
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int w = 0; w < cachePkg::NumWays; w++)
			hitVec[w] = setValid[w] && (tagArray[setIndex][w] == addrTag);
	end

	assign lookup.hit = |hitVec;

	// Downward scans so the lowest way wins
	always_comb
	begin
		lookup.hitWay    = '0;
		lookup.victimWay = '0;
		for (int w = cachePkg::NumWays - 1; w >= 0; w--)
		begin
			if (hitVec[w])
				lookup.hitWay = cachePkg::wayT'(w);
			if (!setUsed[w])
				lookup.victimWay = cachePkg::wayT'(w);
		end
		if (!(&setValid)) // A free way beats the used bits
		begin
			for (int w = cachePkg::NumWays - 1; w >= 0; w--)
			begin
				if (!setValid[w])
					lookup.victimWay = cachePkg::wayT'(w);
			end
		end
	end

	// Touch never leaves all four used bits set
	always_comb
	begin
		touchMask   = cachePkg::NumWays'(1) << lookup.touchWay;
		touchedUsed = setUsed | touchMask;
		if (&touchedUsed)
			touchedUsed = touchMask; // Others cleared, touched one kept
	end

	//////////////////////////////////////////////////////////////////////
	// State update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int s = 0; s < NumSets; s++)
			begin
				validBits[s] <= '0;
				usedBits[s]  <= '0;
			end
		end
		else if (lookup.invalidateAll)
		begin
			for (int s = 0; s < NumSets; s++)
			begin
				validBits[s] <= '0;
				usedBits[s]  <= '0;
			end
		end
		else
		begin
			if (lookup.allocate)
				validBits[setIndex][lookup.victimWay] <= 1'b1;
			if (lookup.invalidateLine && lookup.hit) // Miss leaves the set alone
				validBits[setIndex][lookup.hitWay] <= 1'b0;
			if (lookup.touch)
				usedBits[setIndex] <= touchedUsed;
		end
	end

	always_ff @(posedge clk)
	begin
		if (lookup.allocate)
			tagArray[setIndex][lookup.victimWay] <= addrTag;
	end

endmodule

/* dataStore.sv */
module dataStore
#(
	parameter int NumSets = 16
)
(
	input  logic                       clk,
	input  logic [$clog2(NumSets)-1:0] setIndex,
	input  cachePkg::wayT              accessWay,
	input  cachePkg::wordSelT          wordSel,
	input  logic                       fillWrite, // One beat of a line fill
	input  logic                       wordWrite, // Write hit update
	input  cachePkg::wordT             writeWord,
	output cachePkg::wordT             readWord
);

	// Line data by set, way and word
	cachePkg::wordT lineData [NumSets][cachePkg::NumWays][cachePkg::WordsPerLine];

	// Fill beats and write hits share the single word port
	always_ff @(posedge clk)
	begin
		if (fillWrite || wordWrite)
			lineData[setIndex][accessWay][wordSel] <= writeWord;
	end

	// Combinational word read for cpuRData
	assign readWord = lineData[setIndex][accessWay][wordSel];

endmodule

/* cacheCtrl.sv */
module cacheCtrl
(
	input  logic               clk,
	input  logic               rstN,
	input  logic               cpuReq,
	input  logic               cpuWe,
	input  cachePkg::addrT     cpuAddr,
	input  cachePkg::wordT     cpuWData,
	input  logic               opReq,
	input  cachePkg::opCodeT   opCode,
	output logic               cpuAck,
	output logic               memReq,
	output logic               memWe,
	output cachePkg::addrT     memAddr,
	output cachePkg::wordT     memWData,
	input  logic               memAck,
	tagLookupIf.ctrlPort       lookup,
	output logic               fillWrite,
	output logic               wordWrite,
	output cachePkg::wayT      accessWay,
	input  cachePkg::wordSelT  beatIndex,
	input  logic               lastBeat,
	output logic               beatDone,
	output logic               beatClear
);

	cachePkg::ctrlStateT state;
	cachePkg::addrT      reqAddr;    // Address of the request in service
	cachePkg::opCodeT    reqOp;
	cachePkg::wayT       wayReg;     // Hit or victim way after lookup
	logic                reqWe;
	logic                reqIsOp;    // Request came in on opReq
	logic                lineDone;   // Last fill beat has been taken
	logic                takeReq;    // Idle accepts a request this cycle
	logic                startBeat;  // Fill beat goes out on memReq
	logic                finishFill; // Line complete and memory released
	logic                reqHeld;

	assign takeReq    = (state == cachePkg::idle) && (cpuReq || opReq);
	assign startBeat  = (state == cachePkg::fillRequest) && !memAck;
	assign finishFill = (state == cachePkg::fillRelease) && !memAck && lineDone;
	assign reqHeld    = reqIsOp ? opReq : cpuReq; // Watch the line that was served

	assign lookup.addr     = reqAddr;
	assign lookup.touchWay = accessWay;
	assign accessWay       = (state == cachePkg::lookup) ? lookup.hitWay : wayReg;

	//////////////////////////////////////////////////////////////////////
	// Control state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state    <= cachePkg::idle;
			cpuAck   <= 1'b0;
			memReq   <= 1'b0;
			memWe    <= 1'b0;
			reqWe    <= 1'b0;
			reqIsOp  <= 1'b0;
			lineDone <= 1'b0;
		end
		else
		begin
			case (state)
				cachePkg::idle:
				begin
					if (cpuReq) // CPU access wins over an operation
					begin
						reqIsOp <= 1'b0;
						reqWe   <= cpuWe;
						state   <= cachePkg::lookup;
					end
					else if (opReq)
					begin
						reqIsOp <= 1'b1;
						reqWe   <= 1'b0;
						state   <= cachePkg::lookup;
					end
				end
				cachePkg::lookup:
				begin
					if (reqIsOp || (!reqWe && lookup.hit))
						state <= cachePkg::respond;
					else if (reqWe)
						state <= cachePkg::writeRequest; // Write through on hit and miss
					else
						state <= cachePkg::fillRequest;
				end
				cachePkg::fillRequest:
				begin
					if (startBeat)
					begin
						memReq <= 1'b1;
						memWe  <= 1'b0;
						state  <= cachePkg::fillWait;
					end
				end
				cachePkg::fillWait:
				begin
					if (memAck)
					begin
						memReq   <= 1'b0;
						lineDone <= lastBeat; // Counter moves on at this edge
						state    <= cachePkg::fillRelease;
					end
				end
				cachePkg::fillRelease:
				begin
					if (!memAck)
						state <= lineDone ? cachePkg::respond : cachePkg::fillRequest;
				end
				cachePkg::writeRequest:
				begin
					if (!memAck)
					begin
						memReq <= 1'b1;
						memWe  <= 1'b1;
						state  <= cachePkg::writeWait;
					end
				end
				cachePkg::writeWait:
				begin
					if (memAck)
					begin
						memReq <= 1'b0;
						state  <= cachePkg::writeRelease;
					end
				end
				cachePkg::writeRelease:
				begin
					if (!memAck)
					begin
						memWe <= 1'b0;
						state <= cachePkg::respond;
					end
				end
				cachePkg::respond:
				begin
					if (!cpuAck)
						cpuAck <= 1'b1;
					else if (!reqHeld) // Four phase release
					begin
						cpuAck <= 1'b0;
						state  <= cachePkg::idle;
					end
				end
				default: state <= cachePkg::idle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Request payload and memory address
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (takeReq)
		begin
			reqAddr <= cpuAddr;
			memAddr <= cpuAddr; // Also selects the data store word
			reqOp   <= opCode;
		end
		if (takeReq && cpuReq)
			memWData <= cpuWData;
		if (state == cachePkg::lookup)
			wayReg <= lookup.hit ? lookup.hitWay : lookup.victimWay;
		if (startBeat) // Line aligned beat address
			memAddr <= {reqAddr[cachePkg::AddrWidth-1:cachePkg::OffsetWidth], beatIndex, 2'b00};
		if (finishFill)
			memAddr <= reqAddr; // Back to the requested word for cpuRData
	end

	// One cycle strobes to the stores and the counter
	always_comb
	begin
		lookup.touch          = 1'b0;
		lookup.allocate       = 1'b0;
		lookup.invalidateLine = 1'b0;
		lookup.invalidateAll  = 1'b0;
		fillWrite             = 1'b0;
		wordWrite             = 1'b0;
		beatDone              = 1'b0;
		beatClear             = 1'b0;
		case (state)
			cachePkg::lookup:
			begin
				if (reqIsOp)
				begin
					lookup.invalidateLine = (reqOp == cachePkg::opInvalidateLine);
					lookup.invalidateAll  = (reqOp == cachePkg::opInvalidateAll);
				end
				else if (lookup.hit)
				begin
					lookup.touch = 1'b1;
					wordWrite    = reqWe; // Update the cached copy on write hit
				end
				else if (!reqWe)
				begin
					lookup.allocate = 1'b1; // Victim claimed before the fill
					beatClear       = 1'b1;
				end
			end
			cachePkg::fillWait:
			begin
				fillWrite = memAck;
				beatDone  = memAck;
			end
			cachePkg::fillRelease: lookup.touch = finishFill;
			default: ;
		endcase
	end

endmodule

/* cacheTop.sv */
module cacheTop
#(
	parameter int NumSets = 16
)
(
	input  logic             clk,
	input  logic             rstN,
	input  logic             cpuReq,
	input  logic             cpuWe,
	input  cachePkg::addrT   cpuAddr,
	input  cachePkg::wordT   cpuWData,
	input  logic             opReq,
	input  cachePkg::opCodeT opCode,
	input  logic             memAck,
	input  cachePkg::wordT   memRData,
	output logic             cpuAck,
	output cachePkg::wordT   cpuRData,
	output logic             memReq,
	output logic             memWe,
	output cachePkg::addrT   memAddr,
	output cachePkg::wordT   memWData
);

	localparam int IndexWidth = $clog2(NumSets);

	tagLookupIf lookupIf ();

	logic              fillWrite;
	logic              wordWrite;
	logic              beatDone;
	logic              beatClear;
	logic              lastBeat;
	cachePkg::wayT     accessWay;
	cachePkg::wordSelT beatIndex;

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////

	cacheCtrl cacheCtrl_i
	(
		.clk       (clk),
		.rstN      (rstN),
		.cpuReq    (cpuReq),
		.cpuWe     (cpuWe),
		.cpuAddr   (cpuAddr),
		.cpuWData  (cpuWData),
		.opReq     (opReq),
		.opCode    (opCode),
		.cpuAck    (cpuAck),
		.memReq    (memReq),
		.memWe     (memWe),
		.memAddr   (memAddr),
		.memWData  (memWData),
		.memAck    (memAck),
		.lookup    (lookupIf.ctrlPort),
		.fillWrite (fillWrite),
		.wordWrite (wordWrite),
		.accessWay (accessWay),
		.beatIndex (beatIndex),
		.lastBeat  (lastBeat),
		.beatDone  (beatDone),
		.beatClear (beatClear)
	);

	fillBeatCounter fillBeatCounter_i
	(
		.clk       (clk),
		.rstN      (rstN),
		.beatDone  (beatDone),
		.beatClear (beatClear),
		.beatIndex (beatIndex),
		.lastBeat  (lastBeat)
	);

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	tagStore #(.NumSets(NumSets)) tagStore_i
	(
		.clk    (clk),
		.rstN   (rstN),
		.lookup (lookupIf.storePort)
	);

	// memAddr carries the set and word of every data store access
	dataStore #(.NumSets(NumSets)) dataStore_i
	(
		.clk       (clk),
		.setIndex  (memAddr[cachePkg::OffsetWidth +: IndexWidth]),
		.accessWay (accessWay),
		.wordSel   (memAddr[cachePkg::OffsetWidth-1 -: 2]),
		.fillWrite (fillWrite),
		.wordWrite (wordWrite),
		.writeWord (fillWrite ? memRData : memWData), // Fill word or CPU write word
		.readWord  (cpuRData)
	);

endmodule

/* cacheTop_assertions.sv */
module cacheTop_assertions
(
	input logic           clk,
	input logic           rstN,
	input logic           cpuReq,
	input logic           opReq,
	input logic           cpuAck,
	input logic           memReq,
	input logic           memAck,
	input cachePkg::addrT memAddr
);

	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0; // Polled by tbCache at the end of the run

	// Memory request only once the previous memAck is gone
	newReqAfterAck: assert property (@(posedge clk) disable iff (!rstN)
		$rose(memReq) |-> !$past(memAck))
	else
	begin
		failCount++;
		$error("memReq rose while memAck was high");
	end

	// Four phase CPU side
	ackHeldWithReq: assert property (@(posedge clk) disable iff (!rstN)
		(cpuAck && (cpuReq || opReq)) |=> cpuAck)
	else
	begin
		failCount++;
		$error("cpuAck fell while the request was still high");
	end

	stableMemAddr: assert property (@(posedge clk) disable iff (!rstN)
		(memReq && $past(memReq)) |-> $stable(memAddr)) // Address held for the whole beat
	else
	begin
		failCount++;
		$error("memAddr changed while memReq was high");
	end

endmodule

bind cacheTop cacheTop_assertions handshakeChecks
(
	.clk     (clk),
	.rstN    (rstN),
	.cpuReq  (cpuReq),
	.opReq   (opReq),
	.cpuAck  (cpuAck),
	.memReq  (memReq),
	.memAck  (memAck),
	.memAddr (memAddr)
);

/* tbMemModel.sv */
module tbMemModel
(
	input  logic           clk,
	input  logic           memReq,
	input  logic           memWe,
	input  cachePkg::addrT memAddr,
	input  cachePkg::wordT memWData,
	output logic           memAck,
	output cachePkg::wordT memRData,
	output int             readCount,  // Completed read beats
	output int             writeCount  // Completed write beats
);

	timeunit 1ns;
	timeprecision 100ps;

	cachePkg::wordT memWords [cachePkg::addrT]; // Only words that were written
	logic [31:0]    lfsr = 32'hbd95;
	logic [31:0]    delayBits;
	int             waitLeft;                   // Cycles before the next memAck

	// Unwritten words, every address bit changes the result
	function automatic cachePkg::wordT initialWord(input cachePkg::addrT addr);
		return (addr * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
	endfunction

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic takeBits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			bits = {bits[30:0], lfsr[0]}; // One step per bit
		end
	endtask

	initial
	begin
		memAck     = 1'b0;
		memRData   = '0;
		readCount  = 0;
		writeCount = 0;
		takeBits(2, delayBits);
		waitLeft = int'(delayBits);
		forever
		begin
			@(posedge clk);
			#5; // DUT outputs settled after the edge
			if (memReq && !memAck)
			begin
				if (waitLeft > 0)
					waitLeft--; // Slow memory
				else
				begin
					if (memWe)
					begin
						memWords[memAddr] = memWData;
						writeCount++;
					end
					else
					begin
						memRData = memWords.exists(memAddr) ? memWords[memAddr] :
							initialWord(memAddr);
						readCount++;
					end
					memAck = 1'b1;
				end
			end
			else if (memAck && !memReq)
			begin
				memAck = 1'b0; // Four phase release
				takeBits(2, delayBits);
				waitLeft = int'(delayBits);
			end
		end
	end

endmodule

/* tbCache.sv */
module tbCache;

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [1:0]
	{
		readRow,
		writeRow,
		opRow
	} rowKindT;

	typedef struct packed
	{
		rowKindT          kind;
		cachePkg::addrT   addr;
		cachePkg::opCodeT op;
		cachePkg::wordT   wData;
		cachePkg::wordT   expData;   // cpuRData expected on reads
		int               readDelta; // Memory reads the row should cost
	} rowT;

	logic             clk;
	logic             rstN;
	logic             cpuReq;
	logic             cpuWe;
	cachePkg::addrT   cpuAddr;
	cachePkg::wordT   cpuWData;
	logic             opReq;
	cachePkg::opCodeT opCode;
	logic             memAck;
	cachePkg::wordT   memRData;
	logic             cpuAck;
	cachePkg::wordT   cpuRData;
	logic             memReq;
	logic             memWe;
	cachePkg::addrT   memAddr;
	cachePkg::wordT   memWData;
	int               readCount;
	int               writeCount;

	rowT              rows[$];
	cachePkg::wordT   shadow [cachePkg::addrT]; // What memory holds after the writes so far
	logic [31:0]      lfsr = 32'hbd95;
	int               errors = 0;
	int               failedTests = 0;

	cacheTop #(.NumSets(16)) cacheTop_i
	(
		.clk      (clk),
		.rstN     (rstN),
		.cpuReq   (cpuReq),
		.cpuWe    (cpuWe),
		.cpuAddr  (cpuAddr),
		.cpuWData (cpuWData),
		.opReq    (opReq),
		.opCode   (opCode),
		.memAck   (memAck),
		.memRData (memRData),
		.cpuAck   (cpuAck),
		.cpuRData (cpuRData),
		.memReq   (memReq),
		.memWe    (memWe),
		.memAddr  (memAddr),
		.memWData (memWData)
	);

	tbMemModel memModel_i
	(
		.clk        (clk),
		.memReq     (memReq),
		.memWe      (memWe),
		.memAddr    (memAddr),
		.memWData   (memWData),
		.memAck     (memAck),
		.memRData   (memRData),
		.readCount  (readCount),
		.writeCount (writeCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// Same fill rule as the memory model
	function automatic cachePkg::wordT initialWord(input cachePkg::addrT addr);
		return (addr * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
	endfunction

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
	endfunction

	task automatic takeBits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	task automatic addRow(input rowKindT kind, input cachePkg::addrT addr, input logic [3:0] op,
		input int readDelta);
		rowT r;
		r.kind      = kind;
		r.addr      = addr;
		r.op        = cachePkg::opCodeT'(op);
		r.wData     = '0;
		r.expData   = '0;
		r.readDelta = readDelta;
		if (kind == writeRow)
		begin
			takeBits(32, r.wData);
			shadow[addr] = r.wData;
		end
		else if (kind == readRow)
			r.expData = shadow.exists(addr) ? shadow[addr] : initialWord(addr);
		rows.push_back(r);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus table, lines A to E all land in set 3
	//////////////////////////////////////////////////////////////////////

	task automatic buildTable();
		addRow(readRow,  32'h0000_1030, 4'd0, 4); // A misses into way 0
		addRow(readRow,  32'h0000_1034, 4'd0, 0);
		addRow(readRow,  32'h0000_103c, 4'd0, 0);
		addRow(writeRow, 32'h0000_1038, 4'd0, 0); // Write hit
		addRow(readRow,  32'h0000_1038, 4'd0, 0); // New word straight from the cache
		addRow(writeRow, 32'h0000_7050, 4'd0, 0); // Write miss, memory only
		addRow(readRow,  32'h0000_7050, 4'd0, 4);
		addRow(readRow,  32'h0000_2030, 4'd0, 4); // B way 1
		addRow(readRow,  32'h0000_3030, 4'd0, 4); // C way 2
		addRow(readRow,  32'h0000_4030, 4'd0, 4); // D way 3, used bits fold to 1000
		addRow(readRow,  32'h0000_5030, 4'd0, 4); // E takes way 0 from A, used 1001
		addRow(readRow,  32'h0000_2034, 4'd0, 0); // B hit, used 1011
		addRow(readRow,  32'h0000_1030, 4'd0, 4); // A back over C in way 2
		addRow(opRow,    32'h0000_2030, 4'd3, 0); // Drop B
		addRow(readRow,  32'h0000_4030, 4'd0, 0); // D unaffected
		addRow(readRow,  32'h0000_2038, 4'd0, 4); // B refills the freed way 1
		addRow(opRow,    32'h0000_4030, 4'd7, 0); // Unknown opcode
		addRow(readRow,  32'h0000_403c, 4'd0, 0);
		addRow(opRow,    32'h0000_0000, 4'd4, 0); // Flush everything
		addRow(readRow,  32'h0000_1038, 4'd0, 4); // Write hit word now comes from memory
		addRow(readRow,  32'h0000_7050, 4'd0, 4);
		addRow(readRow,  32'h0000_4034, 4'd0, 4);
		addRow(readRow,  32'h0000_5038, 4'd0, 4); // E gone too
		addRow(readRow,  32'h0000_203c, 4'd0, 4); // And B
	endtask

	task automatic runRow(input int n, input rowT r);
		int readsBefore;
		int writesBefore;
		int errorsBefore;
		int edges;
		readsBefore  = readCount;
		writesBefore = writeCount;
		errorsBefore = errors;
		edges        = 0;
		cpuAddr      = r.addr;
		cpuWData     = r.wData;
		cpuWe        = (r.kind == writeRow);
		opCode       = r.op;
		if (r.kind == opRow)
			opReq = 1'b1;
		else
			cpuReq = 1'b1;
		while (!cpuAck)
		begin
			@(posedge clk);
			#5;
			edges++; // First edge here is the one idle samples
		end
		if (r.kind == readRow && cpuRData !== r.expData)
		begin
			$display("[FAIL] cpuRData: got %h, expected %h", cpuRData, r.expData);
			errors++;
		end
		if (readCount - readsBefore != r.readDelta)
		begin
			$display("[FAIL] readCount delta: got %h, expected %h", readCount - readsBefore,
				r.readDelta);
			errors++;
		end
		if (writeCount - writesBefore != int'(r.kind == writeRow))
		begin
			$display("[FAIL] writeCount delta: got %h, expected %h", writeCount - writesBefore,
				int'(r.kind == writeRow));
			errors++;
		end
		if (r.kind != writeRow && r.readDelta == 0 && edges - 1 != 2) // Hit and op latency
		begin
			$display("cpuAck rose %0d edges after the request was taken instead of 2", edges - 1);
			errors++;
		end
		cpuReq = 1'b0;
		opReq  = 1'b0;
		while (cpuAck)
		begin
			@(posedge clk);
			#5;
		end
		if (errors != errorsBefore)
			failedTests++;
		$display("Test %0d %s %h: %s", n, r.kind.name(), r.addr,
			(errors == errorsBefore) ? "ok" : "mismatch");
	endtask

	initial
	begin
		rstN     = 1'b0;
		cpuReq   = 1'b0;
		cpuWe    = 1'b0;
		cpuAddr  = '0;
		cpuWData = '0;
		opReq    = 1'b0;
		opCode   = cachePkg::opCodeT'(4'd0);
		buildTable();
		repeat (2) @(posedge clk);
		#5;
		if (cpuAck || memReq || memWe)
		begin
			$display("cpuAck, memReq or memWe is not low during reset");
			errors++;
		end
		rstN = 1'b1;
		foreach (rows[i])
			runRow(i, rows[i]);
		$display("%0d tests, %0d passed, %0d failed, %0d assertion failures", rows.size(),
			rows.size() - failedTests, failedTests, cacheTop_i.handshakeChecks.failCount);
		if (errors == 0 && cacheTop_i.handshakeChecks.failCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog, 40 cycles per row plus reset
	initial
	begin
		#1;
		repeat (rows.size() * 40 + 4) @(posedge clk);
		$display("Run did not finish within %0d cycles", rows.size() * 40 + 4);
		$display("Something failed");
		$finish;
	end

endmodule

/* src.f */
cachePkg.sv
tagLookupIf.sv
fillBeatCounter.sv
tagStore.sv
dataStore.sv
cacheCtrl.sv
cacheTop.sv
cacheTop_assertions.sv
tbMemModel.sv
tbCache.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	-f src.f --top-module tbCache -o simCache

# The log decides pass or fail, not the simulator's exit status
./obj_dir/simCache > sim.log 2>&1 || true
cat sim.log
grep -qx "Everything OK" sim.log
